// File: sim.f
hdl/fbp_pkg.sv
hdl/fbp_config_regs.sv
hdl/projection_fir.sv
hdl/filtered_line_ram.sv
hdl/filtered_ram_swap_control.sv
hdl/filtered_projection_top.sv
tests/tb_clock_gen.sv
tests/filtered_projection_props.sv
tests/tb_filtered_projection.sv

// File: Bender.yml
package:
  name: filtered_projection

sources:
  - files:
      - hdl/fbp_pkg.sv
      - hdl/fbp_config_regs.sv
      - hdl/projection_fir.sv
      - hdl/filtered_line_ram.sv
      - hdl/filtered_ram_swap_control.sv
      - hdl/filtered_projection_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/filtered_projection_props.sv
      - tests/tb_filtered_projection.sv

// File: tests/tb_filtered_projection.sv
`timescale 1ns/1ns
`default_nettype none

module tb_filtered_projection
    import fbp_pkg::*;
;

    localparam int CREDITS         = 4;
    localparam int MAX_LINE        = 64;
    localparam int max_lines       = 16;
    localparam int n_angles        = 9;
    localparam int longest_line    = 32;
    localparam int hold_cycles     = 160;
    localparam int watchdog_cycles = n_angles * longest_line * 40 + hold_cycles + 2000;

    logic                       clk;
    logic                       reset_n;
    cfg_write_t                 cfg;
    sample_beat_t               sample;
    logic                       sample_credit;
    logic [angle_len-1:0]       angle;
    logic                       has_next_angle;
    logic                       angle_ack;
    logic                       next_angle;
    logic signed [s_len-1:0]    pr0_s;
    logic signed [s_len-1:0]    pr1_s;
    logic                       angle_swap;
    logic [angle_len-1:0]       pr_angle;
    logic signed [filt_len-1:0] pr0_val;
    logic signed [filt_len-1:0] pr1_val;

    // host side view of the config and of every line sent
    int tb_c0;
    int tb_c1;
    int tb_c2;
    int tb_len;
    int raw_mem [max_lines][MAX_LINE];
    int line_angle [max_lines];
    int line_len_of [max_lines];
    int line_c0 [max_lines];
    int line_c1 [max_lines];
    int line_c2 [max_lines];
    int lines_sent;
    int lines_checked;
    int hold_line;
    int credits;
    int check_count;
    int error_count;
    logic [15:0] lfsr_state;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) i_tb_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    filtered_projection_top #(.CREDITS(CREDITS), .MAX_LINE(MAX_LINE)) i_filtered_projection_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .cfg            (cfg),
        .sample         (sample),
        .sample_credit  (sample_credit),
        .angle          (angle),
        .has_next_angle (has_next_angle),
        .angle_ack      (angle_ack),
        .next_angle     (next_angle),
        .pr0_s          (pr0_s),
        .pr1_s          (pr1_s),
        .angle_swap     (angle_swap),
        .pr_angle       (pr_angle),
        .pr0_val        (pr0_val),
        .pr1_val        (pr1_val)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // y[n] = c1 x[n] + c0 x[n-1] + c2 x[n-2], zero history, clamp to 16 bits
    function automatic int filter_ref(input int li, input int n);
        int acc;
        acc = line_c1[li] * raw_mem[li][n];
        if (n >= 1)
            acc = acc + line_c0[li] * raw_mem[li][n - 1];
        if (n >= 2)
            acc = acc + line_c2[li] * raw_mem[li][n - 2];
        if (acc > 32767)
            acc = 32767;
        else if (acc < -32768)
            acc = -32768;
        return acc;
    endfunction

    // anything off the line reads as zero
    function automatic int expect_at(input int li, input int s);
        if (s < 0 || s >= line_len_of[li])
            return 0;
        return filter_ref(li, s);
    endfunction

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input cfg_addr_t a, input int d);
        @(posedge clk);
        #2;
        cfg = '{wr: 1'b1, addr: a, data: 16'(d)};
        @(posedge clk);
        #2;
        cfg.wr = 1'b0;
    endtask

    // only while the controller idles in ready_s
    task automatic configure(input int c0, input int c1, input int c2, input int len);
        write_reg(cfg_coef0, c0);
        write_reg(cfg_coef1, c1);
        write_reg(cfg_coef2, c2);
        write_reg(cfg_line_len, len);
        tb_c0  = c0;
        tb_c1  = c1;
        tb_c2  = c2;
        tb_len = len;
    endtask

    // ack the angle, stream one line under credits, wait for its swap
    task automatic send_line(input int a, input logic hn, input logic extreme);
        int li;
        int n;
        logic [31:0] bits;
        logic [data_len-1:0] v;
        li = lines_sent;
        line_angle[li]  = a;
        line_len_of[li] = tb_len;
        line_c0[li]     = tb_c0;
        line_c1[li]     = tb_c1;
        line_c2[li]     = tb_c2;
        @(posedge clk);
        #2;
        angle          = angle_len'(a);
        has_next_angle = hn;
        angle_ack      = 1'b1;
        lines_sent     = lines_sent + 1;
        n = 0;
        while (n < tb_len)
        begin
            @(posedge clk);
            #2;
            angle_ack = 1'b0;
            if (credits > 0)
            begin
                if (extreme)
                begin
                    // full scale, either sign
                    take_bits(1, bits);
                    v = bits[0] ? 12'h7ff : 12'h800;
                end
                else
                begin
                    take_bits(data_len, bits);
                    v = bits[data_len-1:0];
                end
                raw_mem[li][n] = $signed(v);
                sample = '{valid: 1'b1, last: (n == tb_len - 1), data: v};
                n++;
            end
            else
                sample = '0;
        end
        @(posedge clk);
        #2;
        sample = '0;
        @(negedge clk);
        while (!angle_swap)
            @(negedge clk);
    endtask

    // host credit counter, one per beat out, one per pulse back
    always @(posedge clk)
    begin
        if (!reset_n)
            credits <= CREDITS;
        else
        begin
            credits <= credits + int'(sample_credit) - int'(sample.valid);
            if (credits > CREDITS)
            begin
                error_count++;
                $display("At %0t ns the DUT returned more credits than beats it got", $time);
            end
        end
    end

    // both ports in one cycle, data one edge later
    task automatic read_pair(input int li, input int s0, input int s1);
        @(posedge clk);
        #2;
        pr0_s = s_len'(s0);
        pr1_s = s_len'(s1);
        @(posedge clk);
        @(negedge clk);
        check_value("pr0_val", pr0_val, expect_at(li, s0));
        check_value("pr1_val", pr1_val, expect_at(li, s1));
    endtask

    // processing side stalls, filled line must wait and credits stop
    task automatic hold_processing(input int cycles);
        int n;
        for (n = 0; n < cycles; n++)
        begin
            @(negedge clk);
            if (angle_swap)
            begin
                error_count++;
                $display("At %0t ns angle_swap fired while next_angle was low", $time);
            end
            if (n >= cycles / 2)
                check_value("sample_credit", sample_credit, 0);
        end
        check_value("credits", credits, CREDITS);
    endtask

    // compare process, one pass per swap
    initial
    begin : compare_lines
        int li;
        int n;
        forever
        begin
            @(negedge clk);
            if (reset_n && angle_swap)
            begin
                li = lines_checked;
                @(posedge clk);
                #2;
                next_angle = 1'b0;
                @(negedge clk);
                check_value("pr_angle", pr_angle, line_angle[li]);
                for (n = 0; n < line_len_of[li]; n++)
                    read_pair(li, n, line_len_of[li] - 1 - n);
                // off the line on both ports
                read_pair(li, -1, line_len_of[li]);
                read_pair(li, line_len_of[li], 63);
                read_pair(li, 63, -1);
                if (li == hold_line)
                    hold_processing(hold_cycles);
                @(posedge clk);
                #2;
                next_angle    = 1'b1;
                lines_checked = lines_checked + 1;
            end
        end
    end

    initial
    begin : stimulus
        int k;
        cfg            = '0;
        sample         = '0;
        angle          = '0;
        has_next_angle = 1'b0;
        angle_ack      = 1'b0;
        next_angle     = 1'b1;
        pr0_s          = '0;
        pr1_s          = '0;
        lfsr_state     = 16'd23;
        lines_sent     = 0;
        lines_checked  = 0;
        hold_line      = -1;
        check_count    = 0;
        error_count    = 0;
        tb_c0          = 0;
        tb_c1          = 1;
        tb_c2          = 0;
        tb_len         = 16;
        wait (reset_n === 1'b1);

        // reset config passes samples through
        send_line(5, 1'b0, 1'b0);
        wait (lines_checked == lines_sent);

        // ping-pong through fill_and_work_s
        repeat (2) @(posedge clk);
        configure(3, -2, 1, 24);
        for (k = 0; k < 4; k++)
            send_line(10 + k, k < 3, 1'b0);
        wait (lines_checked == lines_sent);

        // full scale input, sums clamp
        repeat (2) @(posedge clk);
        configure(127, 127, 127, 32);
        send_line(100, 1'b0, 1'b1);
        wait (lines_checked == lines_sent);

        // stall after the first swap
        repeat (2) @(posedge clk);
        configure(-1, 4, -1, 20);
        hold_line = lines_sent;
        for (k = 0; k < 3; k++)
            send_line(200 + k, k < 2, 1'b0);
        wait (lines_checked == lines_sent);

        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
                 i_filtered_projection_top.i_swap_control.i_swap_props.fail_count);
        if (error_count == 0 &&
            i_filtered_projection_top.i_swap_control.i_swap_props.fail_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", watchdog_cycles);
        $display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
                 i_filtered_projection_top.i_swap_control.i_swap_props.fail_count);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/filtered_projection_props.sv
`timescale 1ns/1ns
`default_nettype none

module filtered_projection_props
    import fbp_pkg::*;
(
    input logic        clk,
    input logic        reset_n,
    input logic        angle_swap,
    input logic        sample_credit,
    input logic        sw_sel,
    input swap_state_t state
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // swap is a single cycle pulse
    swap_one_cycle: assert property (
        @(posedge clk) disable iff (!reset_n) angle_swap |=> !angle_swap
    )
    else
    begin
        $error("angle_swap stayed high for two cycles");
        fail_count++;
    end

    // both rams busy, so no credit pulse is seen in work_s
    no_credit_in_work: assert property (
        @(posedge clk) disable iff (!reset_n) (state == work_s) |-> !sample_credit
    )
    else
    begin
        $error("sample_credit returned while in work_s");
        fail_count++;
    end

    // select flips only as a result of a swap
    sel_follows_swap: assert property (
        @(posedge clk) disable iff (!reset_n) $changed(sw_sel) |-> $past(angle_swap)
    )
    else
    begin
        $error("select bit changed without angle_swap");
        fail_count++;
    end

endmodule

bind filtered_ram_swap_control filtered_projection_props i_swap_props (
    .clk           (clk),
    .reset_n       (reset_n),
    .angle_swap    (angle_swap),
    .sample_credit (sample_credit),
    .sw_sel        (sw_sel),
    .state         (state)
);

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
)
(
    output logic clk,
    output logic reset_n
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

    // reset low for a few edges, released just after an edge
    initial
    begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/filtered_projection_top.sv
`timescale 1ns/1ns
`default_nettype none

module filtered_projection_top
    import fbp_pkg::*;
#(
    parameter int CREDITS  = 4,
    parameter int MAX_LINE = 64
)
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  cfg_write_t                 cfg,
    input  sample_beat_t               sample,
    output logic                       sample_credit,
    input  logic [angle_len-1:0]       angle,
    input  logic                       has_next_angle,
    input  logic                       angle_ack,
    input  logic                       next_angle,
    input  logic signed [s_len-1:0]    pr0_s,
    input  logic signed [s_len-1:0]    pr1_s,
    output logic                       angle_swap,
    output logic [angle_len-1:0]       pr_angle,
    output logic signed [filt_len-1:0] pr0_val,
    output logic signed [filt_len-1:0] pr1_val
);

    fir_cfg_t                   fir_cfg;
    logic [s_len-1:0]           line_len;
    filt_beat_t                 filt;
    logic                       sw0_write_en;
    logic                       sw1_write_en;
    logic                       sw0_fill_kick;
    logic                       sw1_fill_kick;
    logic                       sw0_fill_done;
    logic                       sw1_fill_done;
    logic signed [filt_len-1:0] sw0_pr0_val;
    logic signed [filt_len-1:0] sw0_pr1_val;
    logic signed [filt_len-1:0] sw1_pr0_val;
    logic signed [filt_len-1:0] sw1_pr1_val;

    fbp_config_regs i_fbp_config_regs (
        .clk      (clk),
        .reset_n  (reset_n),
        .cfg      (cfg),
        .fir_cfg  (fir_cfg),
        .line_len (line_len)
    );

    projection_fir i_projection_fir (
        .clk     (clk),
        .reset_n (reset_n),
        .sample  (sample),
        .fir_cfg (fir_cfg),
        .filt    (filt)
    );

    // ping-pong pair, both see every filtered beat
    filtered_line_ram #(.MAX_LINE(MAX_LINE)) i_sw0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .fill_kick (sw0_fill_kick),
        .filt      (filt),
        .write_en  (sw0_write_en),
        .line_len  (line_len),
        .pr0_s     (pr0_s),
        .pr1_s     (pr1_s),
        .fill_done (sw0_fill_done),
        .pr0_val   (sw0_pr0_val),
        .pr1_val   (sw0_pr1_val)
    );

    filtered_line_ram #(.MAX_LINE(MAX_LINE)) i_sw1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .fill_kick (sw1_fill_kick),
        .filt      (filt),
        .write_en  (sw1_write_en),
        .line_len  (line_len),
        .pr0_s     (pr0_s),
        .pr1_s     (pr1_s),
        .fill_done (sw1_fill_done),
        .pr0_val   (sw1_pr0_val),
        .pr1_val   (sw1_pr1_val)
    );

    filtered_ram_swap_control #(.CREDITS(CREDITS)) i_swap_control (
        .clk            (clk),
        .reset_n        (reset_n),
        .sample_valid   (sample.valid),
        .angle          (angle),
        .has_next_angle (has_next_angle),
        .angle_ack      (angle_ack),
        .next_angle     (next_angle),
        .sw0_fill_done  (sw0_fill_done),
        .sw1_fill_done  (sw1_fill_done),
        .sw0_pr0_val    (sw0_pr0_val),
        .sw0_pr1_val    (sw0_pr1_val),
        .sw1_pr0_val    (sw1_pr0_val),
        .sw1_pr1_val    (sw1_pr1_val),
        .sw0_write_en   (sw0_write_en),
        .sw1_write_en   (sw1_write_en),
        .sw0_fill_kick  (sw0_fill_kick),
        .sw1_fill_kick  (sw1_fill_kick),
        .sample_credit  (sample_credit),
        .angle_swap     (angle_swap),
        .pr_angle       (pr_angle),
        .pr0_val        (pr0_val),
        .pr1_val        (pr1_val),
        .state          ()
    );

endmodule

`default_nettype wire

// File: hdl/filtered_ram_swap_control.sv
`timescale 1ns/1ns
`default_nettype none

module filtered_ram_swap_control
    import fbp_pkg::*;
#(
    parameter int CREDITS = 4
)
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       sample_valid,
    input  logic [angle_len-1:0]       angle,
    input  logic                       has_next_angle,
    input  logic                       angle_ack,
    input  logic                       next_angle,
    input  logic                       sw0_fill_done,
    input  logic                       sw1_fill_done,
    input  logic signed [filt_len-1:0] sw0_pr0_val,
    input  logic signed [filt_len-1:0] sw0_pr1_val,
    input  logic signed [filt_len-1:0] sw1_pr0_val,
    input  logic signed [filt_len-1:0] sw1_pr1_val,
    output logic                       sw0_write_en,
    output logic                       sw1_write_en,
    output logic                       sw0_fill_kick,
    output logic                       sw1_fill_kick,
    output logic                       sample_credit,
    output logic                       angle_swap,
    output logic [angle_len-1:0]       pr_angle,
    output logic signed [filt_len-1:0] pr0_val,
    output logic signed [filt_len-1:0] pr1_val,
    output swap_state_t                state
);

    localparam int owed_len = $clog2(CREDITS + 1);

    // sw_sel 0 means sw0 is read and sw1 fills, 1 the other way round
    logic                 sw_sel;
    logic                 fill_done;
    logic                 swap;
    logic                 ack_seen;
    logic [angle_len-1:0] ack_angle;
    logic                 ram_free;
    logic                 credit_now;
    logic [owed_len-1:0]  owed;
    swap_state_t          next_state;

    assign fill_done = sw_sel ? sw0_fill_done : sw1_fill_done;

    // line complete, host acked it, processing wants the next one
    assign swap       = ack_seen && next_angle && fill_done;
    assign angle_swap = swap;

    assign sw0_write_en = sw_sel;
    assign sw1_write_en = !sw_sel;
    // the ram leaving work is cleared to fill next
    assign sw0_fill_kick = swap && !sw_sel;
    assign sw1_fill_kick = swap && sw_sel;

    // working ram to the processing side
    assign pr0_val = sw_sel ? sw1_pr0_val : sw0_pr0_val;
    assign pr1_val = sw_sel ? sw1_pr1_val : sw0_pr1_val;

    // credits only while the filling ram can still take the line
    assign ram_free   = (state != work_s) && !fill_done;
    assign credit_now = ram_free && (sample_valid || owed != '0);

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (angle_ack)
                    next_state = fill_s;
            fill_s, fill_and_work_s:
                if (swap)
                    next_state = has_next_angle ? fill_and_work_s : work_s;
            work_s:
                if (next_angle)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state         <= ready_s;
            sw_sel        <= 1'b0;
            ack_seen      <= 1'b0;
            owed          <= '0;
            sample_credit <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (swap)
                sw_sel <= !sw_sel;
            // a new ack wins over the clear of the old one
            if (angle_ack)
                ack_seen <= 1'b1;
            else if (swap)
                ack_seen <= 1'b0;
            // withheld credits are paid back once a ram is free
            sample_credit <= credit_now;
            owed          <= owed + owed_len'(sample_valid) - owed_len'(credit_now);
        end
    end

    // angle of the line being filled, then of the working line
    always_ff @(posedge clk)
    begin
        if (angle_ack)
            ack_angle <= angle;
        if (swap)
            pr_angle <= ack_angle;
    end

endmodule

`default_nettype wire

// File: hdl/filtered_line_ram.sv
`timescale 1ns/1ns
`default_nettype none

module filtered_line_ram
    import fbp_pkg::*;
#(
    parameter int MAX_LINE = max_line
)
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       fill_kick,
    input  filt_beat_t                 filt,
    input  logic                       write_en,
    input  logic [s_len-1:0]           line_len,
    input  logic signed [s_len-1:0]    pr0_s,
    input  logic signed [s_len-1:0]    pr1_s,
    output logic                       fill_done,
    output logic signed [filt_len-1:0] pr0_val,
    output logic signed [filt_len-1:0] pr1_val
);

    localparam int addr_len = $clog2(MAX_LINE);

    logic signed [filt_len-1:0] mem [MAX_LINE];
    logic [addr_len-1:0]        wr_addr;
    logic                       wr_fire;

    // s must be non-negative and inside both the line and the ram
    function automatic logic s_in_line(input logic signed [s_len-1:0] s);
        logic [s_len-1:0] u;
        u = s;
        return !s[s_len-1] && (u < line_len) && (u < MAX_LINE);
    endfunction

    // a finished line is protected from stray beats
    assign wr_fire = write_en && filt.valid && !fill_done;

    // fill counter and done flag
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_addr   <= '0;
            fill_done <= 1'b0;
        end
        else if (fill_kick)
        begin
            // rearm for the next line
            wr_addr   <= '0;
            fill_done <= 1'b0;
        end
        else if (wr_fire)
        begin
            wr_addr <= wr_addr + 1'b1;
            if (filt.last)
                fill_done <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire)
            mem[wr_addr] <= filt.data;
    end

    // two registered read ports, zero outside the line
    always_ff @(posedge clk)
    begin
        if (s_in_line(pr0_s))
            pr0_val <= mem[addr_len'(pr0_s)];
        else
            pr0_val <= '0;
        if (s_in_line(pr1_s))
            pr1_val <= mem[addr_len'(pr1_s)];
        else
            pr1_val <= '0;
    end

endmodule

`default_nettype wire

// File: hdl/projection_fir.sv
`timescale 1ns/1ns
`default_nettype none

module projection_fir
    import fbp_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  sample_beat_t sample,
    input  fir_cfg_t     fir_cfg,
    output filt_beat_t   filt
);

    // full precision sum of three products
    localparam int acc_len = data_len + coef_len + 2;

    logic signed [data_len-1:0] x0;
    logic signed [data_len-1:0] x1;
    logic signed [data_len-1:0] x2;
    logic signed [acc_len-1:0]  acc;
    logic signed [filt_len-1:0] sat;
    logic                       valid_q;
    logic                       last_q;
    logic signed [filt_len-1:0] data_q;

    assign x0 = sample.data;

    // coef1 on the current sample so 0,1,0 passes the line through
    assign acc = fir_cfg.coef1 * x0 + fir_cfg.coef0 * x1 + fir_cfg.coef2 * x2;

    // clamp when the bits above the sign do not agree
    always_comb
    begin
        if (&acc[acc_len-1:filt_len-1] || ~|acc[acc_len-1:filt_len-1])
            sat = acc[filt_len-1:0];
        else if (acc[acc_len-1])
            sat = {1'b1, {(filt_len-1){1'b0}}};
        else
            sat = {1'b0, {(filt_len-1){1'b1}}};
    end

    // history and beat flags
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            x1      <= '0;
            x2      <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
        else
        begin
            valid_q <= sample.valid;
            last_q  <= sample.valid && sample.last;
            if (sample.valid)
            begin
                // next line starts from zero history
                if (sample.last)
                begin
                    x1 <= '0;
                    x2 <= '0;
                end
                else
                begin
                    x1 <= x0;
                    x2 <= x1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sample.valid)
            data_q <= sat;
    end

    assign filt = '{valid: valid_q, last: last_q, data: data_q};

endmodule

`default_nettype wire

// File: hdl/fbp_config_regs.sv
`timescale 1ns/1ns
`default_nettype none

module fbp_config_regs
    import fbp_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  cfg_write_t       cfg,
    output fir_cfg_t         fir_cfg,
    output logic [s_len-1:0] line_len
);

    // identity filter and a 16 sample line out of reset
    localparam logic [s_len-1:0] line_len_rst = s_len'(16);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fir_cfg.coef0 <= '0;
            fir_cfg.coef1 <= coef_len'(1);
            fir_cfg.coef2 <= '0;
            line_len      <= line_len_rst;
        end
        else if (cfg.wr)
        begin
            // one register per strobe, low bits of the data field
            case (cfg.addr)
                cfg_coef0:
                    fir_cfg.coef0 <= cfg.data[coef_len-1:0];
                cfg_coef1:
                    fir_cfg.coef1 <= cfg.data[coef_len-1:0];
                cfg_coef2:
                    fir_cfg.coef2 <= cfg.data[coef_len-1:0];
                cfg_line_len:
                    line_len <= cfg.data[s_len-1:0];
                default:
                begin
                    // unmapped address, nothing changes
                    line_len <= line_len;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/fbp_pkg.sv
`default_nettype none

package fbp_pkg;

    // raw host sample and filtered sample widths
    localparam int data_len = 12;
    localparam int filt_len = 16;
    // angle index
    localparam int angle_len = 9;
    // signed detector position, also wide enough for line_len
    localparam int s_len = 7;
    // default depth of one line ram
    localparam int max_line = 64;
    // fir coefficients are signed
    localparam int coef_len = 8;
    // config bus fields
    localparam int cfg_addr_len = 9;
    localparam int cfg_data_len = 16;

    // which ram fills and which one is read
    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_and_work_s,
        work_s
    } swap_state_t;

    // register map of the config block
    typedef enum logic [cfg_addr_len-1:0] {
        cfg_coef0    = 9'h000,
        cfg_coef1    = 9'h001,
        cfg_coef2    = 9'h002,
        cfg_line_len = 9'h003
    } cfg_addr_t;

    typedef struct packed {
        logic                    wr;
        cfg_addr_t               addr;
        logic [cfg_data_len-1:0] data;
    } cfg_write_t;

    // coef1 weights the current sample, coef0 and coef2 the two older ones
    typedef struct packed {
        logic signed [coef_len-1:0] coef0;
        logic signed [coef_len-1:0] coef1;
        logic signed [coef_len-1:0] coef2;
    } fir_cfg_t;

    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic signed [data_len-1:0] data;
    } sample_beat_t;

    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic signed [filt_len-1:0] data;
    } filt_beat_t;

endpackage

`default_nettype wire
